/* hdl/commit_stage.sv */
module commit_stage (
    input  logic              clk,
    input  logic              reset,
    input  csr_pkg::csr_rsp_t i_rsp,
    output logic              o_wb_valid,
    output csr_pkg::reg_idx_t o_wb_rd,
    output csr_pkg::xlen_t    o_wb_data,
    output logic              o_redirect,
    output csr_pkg::xlen_t    o_redirect_pc
);
    import csr_pkg::*;

    logic  wb_fire;
    logic  redirect_fire;
    xlen_t aligned_target;

    assign wb_fire       = i_rsp.valid && i_rsp.wb_en;
    assign redirect_fire = i_rsp.valid && i_rsp.redirect;

    // 4-byte aligned target
    assign aligned_target = {i_rsp.target[31:2], 2'b00};

    always_ff @(posedge clk) begin
        if (reset) begin
            o_wb_valid <= 1'b0;
            o_redirect <= 1'b0;
        end else begin
            o_wb_valid <= wb_fire;
            o_redirect <= redirect_fire;
        end
    end

    // payload held until the next strobe
    always_ff @(posedge clk) begin
        if (wb_fire) begin
            o_wb_rd   <= i_rsp.rd;
            o_wb_data <= i_rsp.rdata;
        end
    end

    always_ff @(posedge clk) begin
        if (redirect_fire) begin
            o_redirect_pc <= aligned_target;
        end
    end

endmodule

/* hdl/csr_file.sv */
module csr_file (
    input  logic              clk,
    input  logic              reset,
    input  csr_pkg::csr_req_t i_req,
    output csr_pkg::csr_rsp_t o_rsp,
    output csr_pkg::xlen_t    o_mstatus,
    output csr_pkg::xlen_t    o_mtvec
);
    import csr_pkg::*;

    xlen_t mstatus;
    xlen_t mie;
    xlen_t mtvec;
    xlen_t mscratch;
    xlen_t mepc;
    xlen_t mcause;
    xlen_t mtval;
    xlen_t mcycle;
    xlen_t minstret;

    xlen_t rdata;
    xlen_t wdata;
    logic  csr_we;
    logic  do_ecall;
    logic  do_mret;

    assign csr_we   = i_req.valid && i_req.is_csr && (i_req.op != CSR_NONE);
    assign do_ecall = i_req.valid && i_req.ecall;
    assign do_mret  = i_req.valid && i_req.mret;

    // old value, unknown addresses read zero
    always_comb begin
        case (i_req.addr)
            CSR_MSTATUS:   rdata = mstatus;
            CSR_MIE:       rdata = mie;
            CSR_MTVEC:     rdata = mtvec;
            CSR_MSCRATCH:  rdata = mscratch;
            CSR_MEPC:      rdata = mepc;
            CSR_MCAUSE:    rdata = mcause;
            CSR_MTVAL:     rdata = mtval;
            CSR_MCYCLE:    rdata = mcycle;
            CSR_MINSTRET:  rdata = minstret;
            CSR_MVENDORID: rdata = MVENDORID_VAL;
            CSR_MARCHID:   rdata = MARCHID_VAL;
            default:       rdata = '0;
        endcase
    end

    // read-modify-write value
    always_comb begin
        case (i_req.op)
            CSR_WRITE: wdata = i_req.wdata;
            CSR_SET:   wdata = rdata | i_req.wdata;
            CSR_CLEAR: wdata = rdata & ~i_req.wdata;
            default:   wdata = rdata;
        endcase
    end

    // trap entry and return touch mpp
    always_ff @(posedge clk) begin
        if (reset) begin
            mstatus <= '0;
        end else if (do_ecall) begin
            mstatus <= mstatus | MSTATUS_MPP_MASK;
        end else if (do_mret) begin
            mstatus <= mstatus & ~MSTATUS_MPP_MASK;
        end else if (csr_we && (i_req.addr == CSR_MSTATUS)) begin
            mstatus <= wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            mepc   <= '0;
            mcause <= '0;
        end else if (do_ecall) begin
            mepc   <= i_req.pc;
            mcause <= MCAUSE_ECALL_M;
        end else if (csr_we) begin
            if (i_req.addr == CSR_MEPC) begin
                mepc <= wdata;
            end
            if (i_req.addr == CSR_MCAUSE) begin
                mcause <= wdata;
            end
        end
    end

    // plain read/write registers
    always_ff @(posedge clk) begin
        if (reset) begin
            mie      <= '0;
            mtvec    <= '0;
            mscratch <= '0;
            mtval    <= '0;
        end else if (csr_we) begin
            case (i_req.addr)
                CSR_MIE:      mie      <= wdata;
                CSR_MTVEC:    mtvec    <= wdata;
                CSR_MSCRATCH: mscratch <= wdata;
                CSR_MTVAL:    mtval    <= wdata;
                default:      ;
            endcase
        end
    end

    // counters ignore csr writes
    always_ff @(posedge clk) begin
        if (reset) begin
            mcycle   <= '0;
            minstret <= '0;
        end else begin
            mcycle <= mcycle + 32'd1;
            if (i_req.valid) begin
                minstret <= minstret + 32'd1;
            end
        end
    end

    always_comb begin
        o_rsp.valid    = i_req.valid;
        o_rsp.wb_en    = i_req.valid && i_req.wb_en;
        o_rsp.rd       = i_req.rd;
        o_rsp.rdata    = rdata;
        o_rsp.redirect = do_ecall || do_mret;
        // unmasked here, commit aligns it
        o_rsp.target   = i_req.ecall ? mtvec : mepc;
    end

    assign o_mstatus = mstatus;
    assign o_mtvec   = mtvec;

endmodule

/* hdl/csr_pkg.sv */
package csr_pkg;

    typedef logic [31:0] xlen_t;
    typedef logic [31:0] inst_t;
    typedef logic [11:0] csr_addr_t;
    typedef logic [4:0]  reg_idx_t;

    // same order as funct3[1:0] of the csr instructions
    typedef enum logic [1:0] {
        CSR_NONE  = 2'b00,
        CSR_WRITE = 2'b01,
        CSR_SET   = 2'b10,
        CSR_CLEAR = 2'b11
    } csr_op_e;

    localparam csr_addr_t CSR_MSTATUS   = 12'h300;
    localparam csr_addr_t CSR_MIE       = 12'h304;
    localparam csr_addr_t CSR_MTVEC     = 12'h305;
    localparam csr_addr_t CSR_MSCRATCH  = 12'h340;
    localparam csr_addr_t CSR_MEPC      = 12'h341;
    localparam csr_addr_t CSR_MCAUSE    = 12'h342;
    localparam csr_addr_t CSR_MTVAL     = 12'h343;
    localparam csr_addr_t CSR_MCYCLE    = 12'hb00;
    localparam csr_addr_t CSR_MINSTRET  = 12'hb02;
    localparam csr_addr_t CSR_MVENDORID = 12'hf11;
    localparam csr_addr_t CSR_MARCHID   = 12'hf12;

    localparam xlen_t MVENDORID_VAL    = 32'h0000_0613;
    localparam xlen_t MARCHID_VAL      = 32'h0000_0015;
    localparam xlen_t MSTATUS_MPP_MASK = 32'h0000_1800;
    localparam xlen_t MCAUSE_ECALL_M   = 32'd11;

    localparam logic [6:0] OPC_SYSTEM = 7'b1110011;
    localparam inst_t      INST_ECALL = 32'h0000_0073;
    localparam inst_t      INST_MRET  = 32'h3020_0073;

    typedef struct packed {
        logic      valid;
        logic      is_csr;
        csr_op_e   op;
        csr_addr_t addr;
        xlen_t     wdata;
        reg_idx_t  rd;
        logic      wb_en;
        logic      ecall;
        logic      mret;
        xlen_t     pc;
    } csr_req_t;

    typedef struct packed {
        logic     valid;
        logic     wb_en;
        reg_idx_t rd;
        xlen_t    rdata;
        logic     redirect;
        xlen_t    target;
    } csr_rsp_t;

endpackage

/* hdl/csr_unit.sv */
module csr_unit (
    input  logic              clk,
    input  logic              reset,
    input  logic              i_valid,
    input  csr_pkg::inst_t    i_inst,
    input  csr_pkg::xlen_t    i_pc,
    input  csr_pkg::xlen_t    i_rs1_data,
    output logic              o_wb_valid,
    output csr_pkg::reg_idx_t o_wb_rd,
    output csr_pkg::xlen_t    o_wb_data,
    output logic              o_redirect,
    output csr_pkg::xlen_t    o_redirect_pc,
    output csr_pkg::xlen_t    o_mstatus,
    output csr_pkg::xlen_t    o_mtvec
);
    import csr_pkg::*;

    csr_req_t req;
    csr_rsp_t rsp;

    sys_decode u_decode (
        .clk        (clk),
        .reset      (reset),
        .i_valid    (i_valid),
        .i_inst     (i_inst),
        .i_pc       (i_pc),
        .i_rs1_data (i_rs1_data),
        .o_req      (req)
    );

    // combinational from req, state updates at the next edge
    csr_file u_csr_file (
        .clk       (clk),
        .reset     (reset),
        .i_req     (req),
        .o_rsp     (rsp),
        .o_mstatus (o_mstatus),
        .o_mtvec   (o_mtvec)
    );

    commit_stage u_commit (
        .clk           (clk),
        .reset         (reset),
        .i_rsp         (rsp),
        .o_wb_valid    (o_wb_valid),
        .o_wb_rd       (o_wb_rd),
        .o_wb_data     (o_wb_data),
        .o_redirect    (o_redirect),
        .o_redirect_pc (o_redirect_pc)
    );

endmodule

/* hdl/sys_decode.sv */
module sys_decode (
    input  logic              clk,
    input  logic              reset,
    input  logic              i_valid,
    input  csr_pkg::inst_t    i_inst,
    input  csr_pkg::xlen_t    i_pc,
    input  csr_pkg::xlen_t    i_rs1_data,
    output csr_pkg::csr_req_t o_req
);
    import csr_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    reg_idx_t   rd;
    reg_idx_t   rs1;
    csr_addr_t  addr;
    logic       is_system;
    logic       is_csr;
    csr_op_e    op;
    xlen_t      operand;
    csr_req_t   req_d;

    assign opcode = i_inst[6:0];
    assign rd     = i_inst[11:7];
    assign funct3 = i_inst[14:12];
    assign rs1    = i_inst[19:15];
    assign addr   = i_inst[31:20];

    assign is_system = (opcode == OPC_SYSTEM);

    // funct3 000 and 100 are not csr accesses
    assign is_csr = is_system && (funct3[1:0] != 2'b00);

    always_comb begin
        op = csr_op_e'(funct3[1:0]);
        if (!is_csr) begin
            op = CSR_NONE;
        end else if ((op != CSR_WRITE) && (rs1 == '0)) begin
            // set/clear with x0 or zimm 0 only reads
            op = CSR_NONE;
        end
    end

    // zimm forms take the rs1 field itself
    assign operand = funct3[2] ? xlen_t'(rs1) : i_rs1_data;

    always_comb begin
        req_d.valid  = i_valid;
        req_d.is_csr = is_csr;
        req_d.op     = op;
        req_d.addr   = addr;
        req_d.wdata  = operand;
        req_d.rd     = rd;
        req_d.wb_en  = is_csr && (rd != '0);
        req_d.ecall  = (i_inst == INST_ECALL);
        req_d.mret   = (i_inst == INST_MRET);
        req_d.pc     = i_pc;
    end

    always_ff @(posedge clk) begin
        o_req <= req_d;
        if (reset) begin
            o_req.valid <= 1'b0;
        end
    end

endmodule

/* sim/csr_unit_assertions.sv */
module csr_unit_assertions (
    input logic              clk,
    input logic              reset,
    input logic              i_wb_valid,
    input csr_pkg::reg_idx_t i_wb_rd,
    input logic              i_redirect,
    input csr_pkg::xlen_t    i_redirect_pc
);
    timeunit 1ns;
    timeprecision 100ps;

    int fail_count = 0;

    redirect_aligned: assert property (
        @(posedge clk) disable iff (reset)
        i_redirect |-> (i_redirect_pc[1:0] == 2'b00)
    ) else begin
        fail_count++;
        $error("redirect target is not 4-byte aligned");
    end

    // registered outputs, so checked one edge later
    quiet_in_reset: assert property (
        @(posedge clk) reset |=> (!i_wb_valid && !i_redirect)
    ) else begin
        fail_count++;
        $error("writeback or redirect strobe high after a reset cycle");
    end

    wb_rd_nonzero: assert property (
        @(posedge clk) disable iff (reset)
        i_wb_valid |-> (i_wb_rd != 5'd0)
    ) else begin
        fail_count++;
        $error("writeback to x0");
    end

endmodule

bind csr_unit csr_unit_assertions u_assertions (
    .clk           (clk),
    .reset         (reset),
    .i_wb_valid    (o_wb_valid),
    .i_wb_rd       (o_wb_rd),
    .i_redirect    (o_redirect),
    .i_redirect_pc (o_redirect_pc)
);

/* sim/csr_unit_tb.sv */
module csr_unit_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import csr_pkg::*;

    localparam int ISSUE_COUNT = 47;
    localparam int CYCLE_LIMIT = ISSUE_COUNT + 200;

    localparam logic [2:0] F3_RW  = 3'b001;
    localparam logic [2:0] F3_RS  = 3'b010;
    localparam logic [2:0] F3_RC  = 3'b011;
    localparam logic [2:0] F3_RSI = 3'b110;
    localparam logic [2:0] F3_RCI = 3'b111;

    typedef struct packed {
        int       due;
        logic     wb_valid;
        reg_idx_t rd;
        xlen_t    data;
        logic     redirect;
        xlen_t    pc;
    } expect_t;

    logic     clk;
    logic     reset;
    logic     i_valid;
    inst_t    i_inst;
    xlen_t    i_pc;
    xlen_t    i_rs1_data;
    logic     o_wb_valid;
    reg_idx_t o_wb_rd;
    xlen_t    o_wb_data;
    logic     o_redirect;
    xlen_t    o_redirect_pc;
    xlen_t    o_mstatus;
    xlen_t    o_mtvec;

    xlen_t   shadow [0:4095];
    expect_t exp_q [$];
    int      cyc = 0;
    int      run_cycles = 0;
    int      instret = 0;
    int      errors = 0;
    int      checks = 0;
    int      test_start = 0;
    int      seed;
    logic    reset_q = 1'b1;
    xlen_t   next_pc;

    csr_unit u_dut (
        .clk           (clk),
        .reset         (reset),
        .i_valid       (i_valid),
        .i_inst        (i_inst),
        .i_pc          (i_pc),
        .i_rs1_data    (i_rs1_data),
        .o_wb_valid    (o_wb_valid),
        .o_wb_rd       (o_wb_rd),
        .o_wb_data     (o_wb_data),
        .o_redirect    (o_redirect),
        .o_redirect_pc (o_redirect_pc),
        .o_mstatus     (o_mstatus),
        .o_mtvec       (o_mtvec)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    always @(posedge clk) begin
        cyc     <= cyc + 1;
        reset_q <= reset;
        if (!reset) begin
            run_cycles <= run_cycles + 1;
        end
        if (cyc >= CYCLE_LIMIT) begin
            $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Simulation FAILED");
            $finish;
        end
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error: %s = %h, expected %h (cycle %0d)", name, got, exp, cyc);
        end
    endtask

    function automatic inst_t encode_csr(input logic [2:0] f3, input reg_idx_t rd,
                                         input reg_idx_t rs1, input csr_addr_t addr);
        return {addr, rs1, f3, rd, 7'b1110011};
    endfunction

    function automatic inst_t encode_addi(input reg_idx_t rd);
        return {12'h001, rd, 3'b000, rd, 7'b0010011};
    endfunction

    // shadow csr state stepped in program order
    function automatic expect_t model_step(input inst_t inst, input xlen_t pc,
                                           input xlen_t rs1_data);
        expect_t    e;
        logic [2:0] f3;
        reg_idx_t   rd;
        reg_idx_t   rs1;
        csr_addr_t  addr;
        xlen_t      old_val;
        xlen_t      src;
        xlen_t      new_val;
        logic       writable;

        f3   = inst[14:12];
        rd   = inst[11:7];
        rs1  = inst[19:15];
        addr = inst[31:20];
        e    = '0;
        e.due = cyc + 2;
        // mcycle has counted the decode edge by the time the csr is read
        shadow[CSR_MCYCLE]   = run_cycles + 1;
        shadow[CSR_MINSTRET] = instret;
        if ((inst[6:0] == 7'b1110011) && (f3[1:0] != 2'b00)) begin
            old_val = shadow[addr];
            src = f3[2] ? xlen_t'(rs1) : rs1_data;
            case (f3[1:0])
                2'b01:   new_val = src;
                2'b10:   new_val = old_val | src;
                default: new_val = old_val & ~src;
            endcase
            writable = addr inside {CSR_MSTATUS, CSR_MIE, CSR_MTVEC, CSR_MSCRATCH,
                                    CSR_MEPC, CSR_MCAUSE, CSR_MTVAL};
            if (writable && ((f3[1:0] == 2'b01) || (rs1 != 5'd0))) begin
                shadow[addr] = new_val;
            end
            e.wb_valid = (rd != 5'd0);
            e.rd       = rd;
            e.data     = old_val;
        end else if (inst == 32'h0000_0073) begin
            e.redirect = 1'b1;
            e.pc       = shadow[CSR_MTVEC] & ~32'd3;
            shadow[CSR_MEPC]    = pc;
            shadow[CSR_MCAUSE]  = MCAUSE_ECALL_M;
            shadow[CSR_MSTATUS] = shadow[CSR_MSTATUS] | MSTATUS_MPP_MASK;
        end else if (inst == 32'h3020_0073) begin
            e.redirect = 1'b1;
            e.pc       = shadow[CSR_MEPC] & ~32'd3;
            shadow[CSR_MSTATUS] = shadow[CSR_MSTATUS] & ~MSTATUS_MPP_MASK;
        end
        instret++;
        return e;
    endfunction

    task automatic issue(input inst_t inst, input xlen_t rs1_data);
        @(negedge clk);
        i_valid    = 1'b1;
        i_inst     = inst;
        i_pc       = next_pc;
        i_rs1_data = rs1_data;
        exp_q.push_back(model_step(inst, next_pc, rs1_data));
        next_pc = next_pc + 32'd4;
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(negedge clk);
            i_valid = 1'b0;
        end
    endtask

    task automatic drain();
        idle(1);
        while (exp_q.size() > 0) begin
            @(negedge clk);
        end
    endtask

    task automatic report_test(input string name);
        $display("test %-12s %s, %0d errors", name,
                 (errors == test_start) ? "ok" : "failed", errors - test_start);
        test_start = errors;
    endtask

    // outputs are due exactly two cycles after the issuing edge
    always @(negedge clk) begin
        expect_t e;
        if (reset_q == 1'b0) begin
            if ((exp_q.size() > 0) && (exp_q[0].due <= cyc)) begin
                e = exp_q.pop_front();
                check_value("o_wb_valid", o_wb_valid, e.wb_valid);
                if (e.wb_valid) begin
                    check_value("o_wb_rd", o_wb_rd, e.rd);
                    check_value("o_wb_data", o_wb_data, e.data);
                end
                check_value("o_redirect", o_redirect, e.redirect);
                if (e.redirect) begin
                    check_value("o_redirect_pc", o_redirect_pc, e.pc);
                end
            end else begin
                check_value("o_wb_valid", o_wb_valid, 1'b0);
                check_value("o_redirect", o_redirect, 1'b0);
            end
        end
    end

    task automatic test_write_read();
        csr_addr_t addrs [4];
        addrs = '{CSR_MSCRATCH, CSR_MTVEC, CSR_MIE, CSR_MTVAL};
        repeat (2) begin
            foreach (addrs[k]) begin
                issue(encode_csr(F3_RW, 5'd5, 5'd7, addrs[k]), $random(seed));
                // rs1 field zero, so the random rs1 value must not be used
                issue(encode_csr(F3_RS, 5'd6, 5'd0, addrs[k]), $random(seed));
            end
        end
        drain();
        report_test("write_read");
    endtask

    task automatic test_set_clear();
        issue(encode_csr(F3_RW, 5'd0, 5'd1, CSR_MSCRATCH), $random(seed));
        issue(encode_csr(F3_RS, 5'd3, 5'd2, CSR_MSCRATCH), $random(seed));
        issue(encode_csr(F3_RC, 5'd3, 5'd2, CSR_MSCRATCH), $random(seed));
        issue(encode_csr(F3_RSI, 5'd4, reg_idx_t'($random(seed)), CSR_MSCRATCH), $random(seed));
        issue(encode_csr(F3_RCI, 5'd4, reg_idx_t'($random(seed)), CSR_MSCRATCH), $random(seed));
        issue(encode_csr(F3_RS, 5'd8, 5'd0, CSR_MSCRATCH), 32'd0);
        drain();
        report_test("set_clear");
    endtask

    task automatic test_read_only();
        csr_addr_t addrs [3];
        addrs = '{CSR_MVENDORID, CSR_MARCHID, 12'h7c0};
        foreach (addrs[k]) begin
            issue(encode_csr(F3_RW, 5'd9, 5'd7, addrs[k]), $random(seed));
            issue(encode_csr(F3_RS, 5'd10, 5'd0, addrs[k]), 32'd0);
        end
        drain();
        report_test("read_only");
    endtask

    task automatic test_ecall();
        // low bits set so the redirect must mask them
        issue(encode_csr(F3_RW, 5'd0, 5'd1, CSR_MTVEC), $random(seed) | 32'd3);
        next_pc = $random(seed);
        issue(32'h0000_0073, 32'd0);
        issue(encode_csr(F3_RS, 5'd11, 5'd0, CSR_MEPC), 32'd0);
        issue(encode_csr(F3_RS, 5'd12, 5'd0, CSR_MCAUSE), 32'd0);
        issue(encode_csr(F3_RS, 5'd13, 5'd0, CSR_MSTATUS), 32'd0);
        drain();
        check_value("o_mstatus", o_mstatus, shadow[CSR_MSTATUS]);
        check_value("o_mtvec", o_mtvec, shadow[CSR_MTVEC]);
        report_test("ecall");
    endtask

    task automatic test_mret();
        issue(encode_csr(F3_RW, 5'd0, 5'd1, CSR_MEPC), $random(seed) | 32'd2);
        issue(32'h3020_0073, 32'd0);
        issue(encode_csr(F3_RS, 5'd14, 5'd0, CSR_MSTATUS), 32'd0);
        issue(encode_csr(F3_RW, 5'd0, 5'd1, CSR_MSCRATCH), $random(seed));
        issue(encode_csr(F3_RS, 5'd15, 5'd0, CSR_MSCRATCH), 32'd0);
        drain();
        check_value("o_mstatus", o_mstatus, shadow[CSR_MSTATUS]);
        report_test("mret");
    endtask

    task automatic test_counters();
        issue(encode_csr(F3_RS, 5'd16, 5'd0, CSR_MINSTRET), 32'd0);
        repeat (3) issue(encode_addi(5'd1), $random(seed));
        idle(2);
        repeat (2) issue(encode_addi(5'd2), $random(seed));
        issue(encode_csr(F3_RS, 5'd17, 5'd0, CSR_MINSTRET), 32'd0);
        issue(encode_csr(F3_RS, 5'd18, 5'd0, CSR_MCYCLE), 32'd0);
        idle(3);
        issue(encode_csr(F3_RS, 5'd19, 5'd0, CSR_MCYCLE), 32'd0);
        drain();
        report_test("counters");
    endtask

    initial begin
        seed       = 97;
        next_pc    = 32'h0000_1000;
        reset      = 1'b1;
        i_valid    = 1'b0;
        i_inst     = '0;
        i_pc       = '0;
        i_rs1_data = '0;
        foreach (shadow[a]) begin
            shadow[a] = '0;
        end
        shadow[CSR_MVENDORID] = MVENDORID_VAL;
        shadow[CSR_MARCHID]   = MARCHID_VAL;
        repeat (2) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        test_write_read();
        test_set_clear();
        test_read_only();
        test_ecall();
        test_mret();
        test_counters();

        errors = errors + u_dut.u_assertions.fail_count;
        $display("checks %0d, errors %0d, assertion failures %0d",
                 checks, errors, u_dut.u_assertions.fail_count);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

/* vlog.f */
hdl/csr_pkg.sv
hdl/sys_decode.sv
hdl/csr_file.sv
hdl/commit_stage.sv
hdl/csr_unit.sv
sim/csr_unit_assertions.sv
sim/csr_unit_tb.sv
